// ==== Makefile ====
VERILATOR ?= verilator
TOP       := prefetch_buffer_tb
RTL_TOP   := prefetch_buffer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG  := Simulation completed successfully

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/fetch_fifo.sv ====
// DEPTH must be a power of two from 2 up to PF_FIFO_DEPTH and no push may occur while full
`timescale 1ns/1ns
`default_nettype none

`include "prefetch_consts.svh"

module fetch_fifo
  import prefetch_pkg::*;
#(
  parameter int unsigned DEPTH = `PF_FIFO_DEPTH
) (
  input  wire            clk,
  input  wire            reset_i,
  input  wire            flush_i,
  input  wire            push_i,
  input  wire            pop_i,
  input  wire instr_t    data_i,
  output instr_t         data_o,
  output logic           empty_o,
  output fifo_cnt_t      cnt_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // Storage, written at wr_ptr and read at rd_ptr
  instr_t mem_q [DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  // One extra bit so a full buffer reads as DEPTH
  logic [PTR_W:0]   cnt_q;

  ////////////////////////////////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      // Flush wins over a push in the same cycle
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap naturally for power-of-two depths
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Head word shows up the cycle after its push
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign cnt_o   = fifo_cnt_t'(cnt_q);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Controller throttling must keep the buffer from overflowing
  a_no_push_full : assert property (@(posedge clk) disable iff (reset_i || flush_i)
    !(push_i && (cnt_q == (PTR_W + 1)'(DEPTH))));

  // Pops only come from an accepted fetch of a stored word
  a_no_pop_empty : assert property (@(posedge clk) disable iff (reset_i || flush_i)
    !(pop_i && empty_o));

endmodule

`default_nettype wire

// ==== hw/instr_bus_if.sv ====
// Read-only instruction bus with in-order responses and no error signalling
`timescale 1ns/1ns
`default_nettype none

module instr_bus_if
  import prefetch_pkg::*;
(
  input  wire         clk,
  input  wire         reset_i,
  // Controller side
  input  wire         trans_valid_i,
  input  wire addr_t  trans_addr_i,
  output logic        trans_ready_o,
  output logic        resp_valid_o,
  output instr_t      resp_rdata_o,
  // Memory side
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  wire         instr_gnt_i,
  input  wire         instr_rvalid_i,
  input  wire instr_t instr_rdata_i
);

  bus_state_e state_q;
  bus_state_e state_d;

  // Address of the request still waiting for its grant
  addr_t addr_q;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    // Transparent by default
    instr_req_o  = trans_valid_i;
    instr_addr_o = trans_addr_i;
    case (state_q)
      BUS_IDLE: begin
        // Not granted right away so freeze the address
        if (trans_valid_i && !instr_gnt_i) begin
          state_d = BUS_WAIT_GNT;
        end
      end
      BUS_WAIT_GNT: begin
        // Replay the captured request whatever the controller now drives
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        if (instr_gnt_i) begin
          state_d = BUS_IDLE;
        end
      end
      default: state_d = BUS_IDLE;
    endcase
  end

  // The grant completes the controller's pending request in either state
  assign trans_ready_o = instr_gnt_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == BUS_IDLE) && trans_valid_i && !instr_gnt_i) begin
      addr_q <= trans_addr_i;
    end
  end

  // Response phase passes straight through
  assign resp_valid_o = instr_rvalid_i;
  assign resp_rdata_o = instr_rdata_i;

  // Address must hold until granted, even across a branch
  a_addr_stable : assert property (@(posedge clk) disable iff (reset_i)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)));

  // Controller only issues word addresses
  a_addr_aligned : assert property (@(posedge clk) disable iff (reset_i)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== hw/prefetch_buffer.sv ====
// Word-aligned fetch on a read-only in-order bus; no compressed targets, hardware loops or errors
`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer
  import prefetch_pkg::*;
(
  input  wire         clk,
  input  wire         reset_i,
  // Core fetch stage
  input  wire         req_i,
  input  wire         branch_i,
  input  wire addr_t  branch_addr_i,
  input  wire         fetch_ready_i,
  output logic        fetch_valid_o,
  output instr_t      fetch_rdata_o,
  output logic        busy_o,
  // Instruction memory
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  wire         instr_gnt_i,
  input  wire instr_t instr_rdata_i,
  input  wire         instr_rvalid_i
);

  // Controller to adapter
  logic      trans_valid;
  logic      trans_ready;
  addr_t     trans_addr;
  // Adapter to controller and FIFO
  logic      resp_valid;
  instr_t    resp_rdata;
  // FIFO control and status
  logic      fifo_push;
  logic      fifo_pop;
  logic      fifo_flush;
  logic      fifo_empty;
  fifo_cnt_t fifo_cnt;
  instr_t    fifo_rdata;

  ////////////////////////////////////////////////////////////
  // Fetch control
  ////////////////////////////////////////////////////////////

  prefetch_controller prefetch_controller_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i),
    .busy_o        (busy_o),
    .fetch_valid_o (fetch_valid_o),
    .trans_valid_o (trans_valid),
    .trans_addr_o  (trans_addr),
    .trans_ready_i (trans_ready),
    .resp_valid_i  (resp_valid),
    .fifo_push_o   (fifo_push),
    .fifo_pop_o    (fifo_pop),
    .fifo_flush_o  (fifo_flush),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty)
  );

  // Word store between bus and core
  fetch_fifo fetch_fifo_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .data_i  (resp_rdata),
    .data_o  (fifo_rdata),
    .empty_o (fifo_empty),
    .cnt_o   (fifo_cnt)
  );

  // Oldest buffered word first, otherwise the word arriving now
  assign fetch_rdata_o = fifo_empty ? resp_rdata : fifo_rdata;

  ////////////////////////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////////////////////////

  instr_bus_if instr_bus_if_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .trans_valid_i  (trans_valid),
    .trans_addr_i   (trans_addr),
    .trans_ready_o  (trans_ready),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

endmodule

`default_nettype wire

// ==== hw/prefetch_consts.svh ====
// Fixed 32-bit address and data widths; the FIFO depth must be a power of two and at least 2
`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

// Byte address of an instruction word
`define PF_ADDR_W 32

// One instruction word per bus beat
`define PF_DATA_W 32

////////////////////////////////////////////////////////////
// Buffering
////////////////////////////////////////////////////////////

// Words held in the FIFO, also the cap on requests in flight
`define PF_FIFO_DEPTH 4

`endif

// ==== hw/prefetch_controller.sv ====
// Branches need req_i high and a word target; requests in flight plus stored words stay within depth
`timescale 1ns/1ns
`default_nettype none

`include "prefetch_consts.svh"

module prefetch_controller
  import prefetch_pkg::*;
(
  input  wire            clk,
  input  wire            reset_i,
  // Core side
  input  wire            req_i,
  input  wire            branch_i,
  input  wire addr_t     branch_addr_i,
  input  wire            fetch_ready_i,
  output logic           busy_o,
  output logic           fetch_valid_o,
  // Bus adapter side
  output logic           trans_valid_o,
  output addr_t          trans_addr_o,
  input  wire            trans_ready_i,
  input  wire            resp_valid_i,
  // FIFO side
  output logic           fifo_push_o,
  output logic           fifo_pop_o,
  output logic           fifo_flush_o,
  input  wire fifo_cnt_t fifo_cnt_i,
  input  wire            fifo_empty_i
);

  localparam int unsigned DEPTH = `PF_FIFO_DEPTH;
  localparam int unsigned SUM_W = $bits(fifo_cnt_t) + 1;

  // Next sequential fetch address
  addr_t     addr_q;
  addr_t     branch_target;
  // Accepted requests whose response has not returned
  fifo_cnt_t out_cnt_q;
  // Old-stream responses still to be dropped
  fifo_cnt_t disc_cnt_q;
  fifo_cnt_t disc_cnt_d;
  // Request presented last cycle and not accepted, adapter holds it
  logic      pend_q;
  // That held request belongs to the stream before a branch
  logic      stale_q;

  logic [SUM_W-1:0] fill;
  fifo_cnt_t        fifo_used;
  logic             room;
  logic             accept;
  logic             accept_stale;
  logic             discard;
  logic             keep;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  assign branch_target = {branch_addr_i[`PF_ADDR_W-1:2], 2'b00};

  // FIFO contents do not count in a branch cycle since they get flushed
  assign fifo_used = branch_i ? '0 : fifo_cnt_i;
  assign fill      = {1'b0, out_cnt_q} + {1'b0, fifo_used};
  assign room      = (fill < SUM_W'(DEPTH));

  // Valid stays up once raised until the adapter takes it
  assign trans_valid_o = pend_q || (req_i && room);
  // Branch target goes out in the branch cycle itself
  assign trans_addr_o  = branch_i ? branch_target : addr_q;

  assign accept       = trans_valid_o && trans_ready_i;
  // Grant of a held request that a branch has since overtaken
  assign accept_stale = accept && pend_q && (stale_q || branch_i);

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  // Anything returning in a branch cycle is old stream
  assign discard = resp_valid_i && (branch_i || (disc_cnt_q != '0));
  assign keep    = resp_valid_i && !discard;

  // Fall-through when nothing is buffered
  assign fetch_valid_o = !branch_i && (!fifo_empty_i || keep);
  assign fifo_pop_o    = fetch_valid_o && fetch_ready_i && !fifo_empty_i;
  assign fifo_push_o   = keep && !(fifo_empty_i && fetch_ready_i);
  assign fifo_flush_o  = branch_i;

  assign busy_o = (out_cnt_q != '0) || pend_q;

  always_comb begin
    disc_cnt_d = disc_cnt_q;
    if (branch_i) begin
      // Every response still in flight is now stale
      disc_cnt_d = out_cnt_q - fifo_cnt_t'(resp_valid_i);
    end else if (discard) begin
      disc_cnt_d = disc_cnt_q - fifo_cnt_t'(1);
    end
    // A replayed old request adds one more to drop
    disc_cnt_d = disc_cnt_d + fifo_cnt_t'(accept_stale);
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      addr_q     <= '0;
      out_cnt_q  <= '0;
      disc_cnt_q <= '0;
      pend_q     <= 1'b0;
      stale_q    <= 1'b0;
    end else begin
      out_cnt_q  <= out_cnt_q + fifo_cnt_t'(accept) - fifo_cnt_t'(resp_valid_i);
      disc_cnt_q <= disc_cnt_d;
      pend_q     <= trans_valid_o && !trans_ready_i;
      if (accept) begin
        stale_q <= 1'b0;
      end else if (branch_i && pend_q) begin
        stale_q <= 1'b1;
      end
      // Advance only on a request of the current stream
      if (accept && !accept_stale) begin
        addr_q <= trans_addr_o + addr_t'(4);
      end else if (branch_i) begin
        addr_q <= branch_target;
      end
    end
  end

  // Core only branches while it fetches
  a_branch_req : assert property (@(posedge clk) disable iff (reset_i)
    branch_i |-> req_i);

  // Throttle keeps every outstanding word a home in the FIFO
  a_cnt_limit : assert property (@(posedge clk) disable iff (reset_i)
    ({1'b0, out_cnt_q} + {1'b0, fifo_cnt_i}) <= SUM_W'(DEPTH));

endmodule

`default_nettype wire

// ==== hw/prefetch_pkg.sv ====
// Types follow the widths in prefetch_consts.svh and fifo_cnt_t counts up to PF_FIFO_DEPTH only
`default_nettype none

`include "prefetch_consts.svh"

package prefetch_pkg;

  // Byte address on the instruction bus
  typedef logic [`PF_ADDR_W-1:0] addr_t;

  // Raw instruction word as returned by memory
  typedef logic [`PF_DATA_W-1:0] instr_t;

  // Counts 0 to PF_FIFO_DEPTH inclusive
  // Used for FIFO fill level and for requests in flight
  typedef logic [$clog2(`PF_FIFO_DEPTH + 1)-1:0] fifo_cnt_t;

  // Bus adapter FSM states
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT_GNT
  } bus_state_e;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/prefetch_pkg.sv
hw/fetch_fifo.sv
hw/instr_bus_if.sv
hw/prefetch_controller.sv
hw/prefetch_buffer.sv
tests/prefetch_buffer_tb.sv

// ==== tests/prefetch_buffer_tb.sv ====
// Self-checking testbench with its own memory model; expects PF_FIFO_DEPTH words at most in flight
`timescale 1ns/1ns
`default_nettype none

`include "prefetch_consts.svh"

module prefetch_buffer_tb
  import prefetch_pkg::*;
;

  localparam int TOTAL_WORDS = 16 + 200 + 20 * 6 + 8 + 16;
  // Worst case cycles per word under random stalls, times a margin of 4
  localparam int WATCHDOG_NS = TOTAL_WORDS * 24 * 4 * 8;
  localparam int MODE_ON   = 0;
  localparam int MODE_RAND = 1;
  localparam int MODE_OFF  = 2;

  logic clk = 1'b0;
  logic reset_i;
  logic req_i;
  logic branch_i;
  addr_t branch_addr_i;
  // Memory model inputs, driven by drive_mem from the first edge on
  logic fetch_ready_i = 1'b1;
  logic instr_gnt_i = 1'b0;
  logic instr_rvalid_i = 1'b0;
  instr_t instr_rdata_i = '0;
  logic fetch_valid_o;
  logic busy_o;
  logic instr_req_o;
  instr_t fetch_rdata_o;
  addr_t instr_addr_o;

  logic [31:0] lfsr = 32'h6260_c582;
  int gnt_mode = MODE_ON;
  int ready_mode = MODE_ON;
  // Extra response latency for a grant in the current cycle
  int resp_delay = 0;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int accepted = 0;
  int granted = 0;
  int answered = 0;
  int test_err_start = 0;
  addr_t exp_addr = '0;
  addr_t last_gnt_addr = '0;
  // Granted addresses and the cycle their response is due
  addr_t resp_addr[$];
  int    resp_due[$];
  logic  prev_wait = 1'b0;
  addr_t prev_addr = '0;

  always #4 clk = ~clk;

  prefetch_buffer prefetch_buffer_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_ready_i  (fetch_ready_i),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  // Fixed scramble of the address, shared by memory and checker
  function automatic instr_t mem_word(input addr_t a);
    return ((a ^ 32'h5a5a_1234) * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] draw(input int n);
    logic fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s done with %0d errors", tests, name, errors - test_err_start);
    test_err_start = errors;
  endtask

  // Returns just after the monitor has seen enough accepted words
  task automatic wait_words(input int n);
    int target;
    int limit;
    target = accepted + n;
    limit = 0;
    while (accepted < target && limit < n * 40 + 50) begin
      @(negedge clk);
      #1;
      limit++;
    end
    if (accepted < target) begin
      errors++;
      $display("Timed out waiting for %0d fetched words at %0t ns", n, $time);
    end
  endtask

  task automatic do_branch(input addr_t target);
    @(posedge clk);
    req_i         <= 1'b1;
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model and core-side ready
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : drive_mem
    logic [31:0] b;
    b = draw(2);
    instr_gnt_i <= (gnt_mode == MODE_RAND) ? (b[1:0] != 2'b00) : (gnt_mode == MODE_ON);
    b = draw(2);
    fetch_ready_i <= (ready_mode == MODE_RAND) ? (b[1:0] != 2'b00) : (ready_mode == MODE_ON);
    // Random latency only under random grants, one cycle otherwise
    b = draw(2);
    resp_delay = (gnt_mode == MODE_RAND) ? int'(b[1:0]) : 0;
    if (resp_due.size() > 0 && resp_due[0] <= cyc + 1) begin
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= mem_word(resp_addr[0]);
      void'(resp_due.pop_front());
      void'(resp_addr.pop_front());
    end else begin
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
    end
  end

  // Samples in the middle of the cycle where every output is settled
  always @(negedge clk) begin : monitor
    cyc++;
    if (reset_i) begin
      check_val("instr_req_o in reset", 32'(instr_req_o), 32'd0);
      check_val("fetch_valid_o in reset", 32'(fetch_valid_o), 32'd0);
      check_val("busy_o in reset", 32'(busy_o), 32'd0);
      prev_wait = 1'b0;
    end else begin
      if (branch_i) begin
        check_val("fetch_valid_o in branch cycle", 32'(fetch_valid_o), 32'd0);
        exp_addr = {branch_addr_i[31:2], 2'b00};
      end
      if (prev_wait) begin
        check_val("instr_req_o while waiting", 32'(instr_req_o), 32'd1);
        check_val("instr_addr_o while waiting", instr_addr_o, prev_addr);
      end
      if (instr_req_o) begin
        check_val("instr_addr_o alignment", 32'(instr_addr_o[1:0]), 32'd0);
      end
      if (instr_req_o && instr_gnt_i) begin
        resp_addr.push_back(instr_addr_o);
        resp_due.push_back(cyc + 1 + resp_delay);
        last_gnt_addr = instr_addr_o;
        granted++;
      end
      if (instr_rvalid_i) begin
        answered++;
      end
      if (granted - answered > `PF_FIFO_DEPTH) begin
        errors++;
        $display("Too many requests in flight at %0t ns", $time);
      end
      if (fetch_valid_o && fetch_ready_i) begin
        check_val("fetch_rdata_o", fetch_rdata_o, mem_word(exp_addr));
        exp_addr = exp_addr + 32'd4;
        accepted++;
      end
      prev_wait = instr_req_o && !instr_gnt_i;
      prev_addr = instr_addr_o;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    reset_i = 1'b1;
    req_i = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = '0;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    // Idle with req_i low
    repeat (5) begin
      @(negedge clk);
      check_val("instr_req_o idle", 32'(instr_req_o), 32'd0);
      check_val("busy_o idle", 32'(busy_o), 32'd0);
      check_val("fetch_valid_o idle", 32'(fetch_valid_o), 32'd0);
    end
    end_test("reset state");

    // Immediate grant, one-cycle response, first word right after the branch cycle
    do_branch(32'h0000_1000);
    @(negedge clk);
    // Past the monitor for this cycle
    #1;
    check_val("fetch_valid_o after branch", 32'(fetch_valid_o), 32'd1);
    wait_words(16);
    end_test("sequential stream");

    @(negedge clk);
    gnt_mode = MODE_RAND;
    ready_mode = MODE_RAND;
    do_branch(32'h0002_0040);
    wait_words(200);
    end_test("random stalls");

    for (int i = 0; i < 20; i++) begin
      do_branch(32'h0003_0000 + 32'(i) * 32'h124);
      wait_words(1 + i % 6);
    end
    end_test("branch in flight");

    // Withheld grant across a branch
    @(negedge clk);
    gnt_mode = MODE_OFF;
    ready_mode = MODE_ON;
    do_branch(32'h0004_0000);
    repeat (3) @(posedge clk);
    do_branch(32'h0005_0100);
    repeat (3) @(posedge clk);
    @(negedge clk);
    gnt_mode = MODE_ON;
    wait_words(8);
    end_test("withheld grant");

    @(negedge clk);
    gnt_mode = MODE_RAND;
    ready_mode = MODE_OFF;
    do_branch(32'h0006_0000);
    repeat (12) @(posedge clk);
    req_i <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < 60 && busy_o; i++) begin
      @(negedge clk);
    end
    check_val("busy_o after drain", 32'(busy_o), 32'd0);
    // Draining frees room, yet nothing new goes out with req_i low
    ready_mode = MODE_RAND;
    for (int i = 0; i < 60 && fetch_valid_o; i++) begin
      @(negedge clk);
      check_val("instr_req_o after stop", 32'(instr_req_o), 32'd0);
    end
    check_val("fetch_valid_o after drain", 32'(fetch_valid_o), 32'd0);
    repeat (10) begin
      @(negedge clk);
      check_val("instr_req_o after stop", 32'(instr_req_o), 32'd0);
    end
    #1;
    // Every granted word of the stream reached the core
    check_val("next address after drain", exp_addr, last_gnt_addr + 32'd4);
    end_test("stop and drain");

    $display("%0d tests, %0d checks, %0d errors, %0d words fetched", tests, checks, errors,
             accepted);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
